// File: hw/fetchPkg.sv
package fetchPkg;

    // Byte address, one word wide
    typedef logic [31:0] Addr;

    // Block index, address bits 31 to 4
    typedef logic [27:0] BlockAddr;

    // Halfword position inside a 16-byte block
    typedef logic [2:0] HalfOffs;

    // Packet sequence number
    typedef logic [4:0] FetchId;

    // Eight raw halfwords
    typedef logic [127:0] InstrBlock;

    typedef enum logic [1:0] {
        faultNone,
        faultAccess,
        faultPriv,
        faultInterrupt
    } FetchFault;

    typedef enum logic {
        privUser,
        privSupervisor
    } PrivLevel;

    localparam Addr entryPoint = 32'h0000_1000;

    // Top address nibble of the memory-mapped region
    localparam logic [3:0] mmioRegion = 4'hF;

endpackage

// File: hw/predPkg.sv
package predPkg;

    localparam int btbEntries = 16;

    // Block address bits 7 to 4
    typedef logic [3:0] BtbIndex;

    // Address bits 31 to 8
    typedef logic [23:0] BtbTag;

    // Saturating taken counter
    typedef logic [1:0] Counter;

    // Weakly not taken
    localparam Counter counterInit = 2'd1;

    // Lowest counter value that predicts taken
    localparam Counter counterTaken = 2'd2;

endpackage

// File: hw/predIf.sv
`timescale 1ns/1ps

interface predIf;
    import fetchPkg::*;

    logic hit;
    logic taken;
    Addr target;
    HalfOffs offs;
    logic isJump;

    modport source (
        output hit,
        output taken,
        output target,
        output offs,
        output isJump
    );

    modport sink (
        input hit,
        input taken,
        input target,
        input offs,
        input isJump
    );

endinterface

// File: hw/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor (
    input  logic              clk,
    input  logic              rst,
    input  fetchPkg::Addr     pc,
    input  logic              updValid,
    input  fetchPkg::Addr     updPc,
    input  fetchPkg::Addr     updTarget,
    input  logic              updTaken,
    input  logic              updIsJump,
    input  fetchPkg::HalfOffs updOffs,
    predIf.source             pred
);
    import fetchPkg::*;
    import predPkg::*;

    logic [btbEntries-1:0] entValid;
    BtbTag entTag [btbEntries];
    Addr entTarget [btbEntries];
    HalfOffs entOffs [btbEntries];
    logic entJump [btbEntries];
    Counter entCtr [btbEntries];

    BtbIndex lookIdx;
    BtbTag lookTag;
    BtbIndex updIdx;
    BtbTag updTag;
    logic updHit;

    assign lookIdx = pc[7:4];
    assign lookTag = pc[31:8];
    assign updIdx = updPc[7:4];
    assign updTag = updPc[31:8];

    // Update matches on the tag alone, the offset is refreshed on a taken update
    assign updHit = entValid[updIdx] && (entTag[updIdx] == updTag);

    // A branch behind the fetch position cannot redirect this fetch
    assign pred.hit = entValid[lookIdx] && (entTag[lookIdx] == lookTag)
        && (entOffs[lookIdx] >= pc[3:1]);
    assign pred.taken = entJump[lookIdx] || (entCtr[lookIdx] >= counterTaken);
    assign pred.target = entTarget[lookIdx];
    assign pred.offs = entOffs[lookIdx];
    assign pred.isJump = entJump[lookIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
        end else if (updValid && updTaken) begin
            entValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            if (updHit) begin
                if (updTaken) begin
                    if (entCtr[updIdx] != '1) begin
                        entCtr[updIdx] <= entCtr[updIdx] + 2'd1;
                    end
                    entTarget[updIdx] <= updTarget;
                    entOffs[updIdx] <= updOffs;
                    entJump[updIdx] <= updIsJump;
                end else if (entCtr[updIdx] != '0) begin
                    entCtr[updIdx] <= entCtr[updIdx] - 2'd1;
                end
            end else if (updTaken) begin
                // New entries start one step into taken
                entTag[updIdx] <= updTag;
                entTarget[updIdx] <= updTarget;
                entOffs[updIdx] <= updOffs;
                entJump[updIdx] <= updIsJump;
                entCtr[updIdx] <= counterInit + 2'd1;
            end
        end
    end

    // Targets come from the back end and must land on a halfword
    targetAligned: assert property (
        @(posedge clk) disable iff (rst)
        (updValid && updTaken) |-> (updTarget[0] == 1'b0)
    );

endmodule

// File: hw/fetchGuard.sv
`timescale 1ns/1ps

module fetchGuard (
    input  fetchPkg::Addr       pc,
    input  fetchPkg::PrivLevel  priv,
    input  logic                interruptPending,
    output fetchPkg::FetchFault fault
);
    import fetchPkg::*;

    logic inMmio;
    logic userHigh;

    // No instruction fetch from device space
    assign inMmio = (pc[31:28] == mmioRegion);

    // Upper half of the address space is supervisor only
    assign userHigh = (priv == privUser) && pc[31];

    always_comb begin
        if (inMmio) begin
            fault = faultAccess;
        end else if (userHigh) begin
            fault = faultPriv;
        end else if (interruptPending) begin
            fault = faultInterrupt;
        end else begin
            fault = faultNone;
        end
    end

endmodule

// File: hw/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                redirectValid,
    input  fetchPkg::Addr       redirectPc,
    input  fetchPkg::FetchId    redirectFetchId,
    output fetchPkg::Addr       pc,
    predIf.sink                 pred,
    input  fetchPkg::FetchFault fault,
    output logic                instrReadEnable,
    output fetchPkg::BlockAddr  instrAddr,
    input  fetchPkg::InstrBlock instrRaw,
    output logic                outValid,
    output fetchPkg::Addr       outPc,
    output fetchPkg::FetchId    outFetchId,
    output fetchPkg::FetchFault outFault,
    output fetchPkg::InstrBlock outInstrs,
    output fetchPkg::HalfOffs   outFirstValid,
    output fetchPkg::HalfOffs   outLastValid,
    output logic                outPredTaken,
    output fetchPkg::Addr       outPredTarget
);
    import fetchPkg::*;

    Addr pcReg;
    FetchId nextId;
    logic fetchArmed;
    logic faultLatch;

    // Stage 1 holds the fetch whose memory data is arriving
    logic s1Valid;
    Addr s1Pc;
    logic s1Taken;
    Addr s1Target;
    HalfOffs s1Offs;
    FetchFault s1Fault;

    logic outValidReg;
    InstrBlock rawBackup;
    logic useBackup;
    InstrBlock rawSel;

    logic fetchGo;
    logic predTaken;
    Addr nextPc;

    assign pc = pcReg;
    assign instrAddr = pcReg[31:4];

    // A faulting fetch still takes a slot but sends no read
    assign fetchGo = fetchArmed && !faultLatch && !redirectValid;
    assign instrReadEnable = fetchGo && en && (fault == faultNone);

    assign outValid = outValidReg && en;
    assign rawSel = useBackup ? rawBackup : instrRaw;

    always_comb begin
        predTaken = pred.hit && (pred.taken || pred.isJump);
        if (predTaken) begin
            nextPc = pred.target;
        end else if (pred.hit && (pred.offs != 3'd7)) begin
            // Continue right behind a not-taken branch
            nextPc = {pcReg[31:4], pred.offs + 3'd1, 1'b0};
        end else begin
            nextPc = {pcReg[31:4] + 28'd1, 4'd0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= entryPoint;
            nextId <= '0;
            fetchArmed <= 1'b0;
            faultLatch <= 1'b0;
            s1Valid <= 1'b0;
            outValidReg <= 1'b0;
        end else begin
            fetchArmed <= 1'b1;
            if (redirectValid) begin
                pcReg <= redirectPc;
                nextId <= redirectFetchId + 5'd1;
                faultLatch <= 1'b0;
                s1Valid <= 1'b0;
                outValidReg <= 1'b0;
            end else if (en) begin
                outValidReg <= s1Valid;
                if (s1Valid) begin
                    nextId <= nextId + 5'd1;
                end
                s1Valid <= fetchGo;
                if (fetchGo) begin
                    if (fault != faultNone) begin
                        faultLatch <= 1'b1;
                    end else begin
                        pcReg <= nextPc;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && fetchGo) begin
            s1Pc <= pcReg;
            s1Taken <= predTaken && (fault == faultNone);
            s1Target <= pred.target;
            s1Offs <= pred.offs;
            s1Fault <= fault;
        end
        if (en && s1Valid && !redirectValid) begin
            outPc <= s1Pc;
            outFetchId <= nextId;
            outFault <= s1Fault;
            outInstrs <= (s1Fault != faultNone) ? '0 : rawSel;
            outFirstValid <= s1Pc[3:1];
            outLastValid <= s1Taken ? s1Offs : 3'd7;
            outPredTaken <= s1Taken;
            outPredTarget <= s1Taken ? s1Target : '0;
        end
    end

    // Memory data for a stalled stage 1 is only on the bus for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            useBackup <= 1'b0;
        end else begin
            useBackup <= !en;
        end
    end

    always_ff @(posedge clk) begin
        if (!en) begin
            rawBackup <= rawSel;
        end
    end

    // A redirect flushes both stages before any packet can leave
    noPacketAfterRedirect: assert property (
        @(posedge clk) disable iff (rst)
        ($past(redirectValid) || $past(redirectValid, 2)) |-> !outValid
    );

    // The fault latch holds off reads until the back end redirects
    noReadWhileFaulted: assert property (
        @(posedge clk) disable iff (rst)
        (faultLatch && !redirectValid) |=> !instrReadEnable
    );

endmodule

// File: hw/fetchTop.sv
`timescale 1ns/1ps

module fetchTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                redirectValid,
    input  fetchPkg::Addr       redirectPc,
    input  fetchPkg::FetchId    redirectFetchId,
    input  fetchPkg::PrivLevel  priv,
    input  logic                interruptPending,
    input  logic                updValid,
    input  fetchPkg::Addr       updPc,
    input  fetchPkg::Addr       updTarget,
    input  logic                updTaken,
    input  logic                updIsJump,
    input  fetchPkg::HalfOffs   updOffs,
    output logic                instrReadEnable,
    output fetchPkg::BlockAddr  instrAddr,
    input  fetchPkg::InstrBlock instrRaw,
    output logic                outValid,
    output fetchPkg::Addr       outPc,
    output fetchPkg::FetchId    outFetchId,
    output fetchPkg::FetchFault outFault,
    output fetchPkg::InstrBlock outInstrs,
    output fetchPkg::HalfOffs   outFirstValid,
    output fetchPkg::HalfOffs   outLastValid,
    output logic                outPredTaken,
    output fetchPkg::Addr       outPredTarget
);
    import fetchPkg::*;

    Addr fetchPc;
    FetchFault guardFault;

    predIf predBus ();

    branchPredictor bp (
        .clk       (clk),
        .rst       (rst),
        .pc        (fetchPc),
        .updValid  (updValid),
        .updPc     (updPc),
        .updTarget (updTarget),
        .updTaken  (updTaken),
        .updIsJump (updIsJump),
        .updOffs   (updOffs),
        .pred      (predBus.source)
    );

    fetchGuard guard (
        .pc               (fetchPc),
        .priv             (priv),
        .interruptPending (interruptPending),
        .fault            (guardFault)
    );

    fetchSequencer seq (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .redirectValid   (redirectValid),
        .redirectPc      (redirectPc),
        .redirectFetchId (redirectFetchId),
        .pc              (fetchPc),
        .pred            (predBus.sink),
        .fault           (guardFault),
        .instrReadEnable (instrReadEnable),
        .instrAddr       (instrAddr),
        .instrRaw        (instrRaw),
        .outValid        (outValid),
        .outPc           (outPc),
        .outFetchId      (outFetchId),
        .outFault        (outFault),
        .outInstrs       (outInstrs),
        .outFirstValid   (outFirstValid),
        .outLastValid    (outLastValid),
        .outPredTaken    (outPredTaken),
        .outPredTarget   (outPredTarget)
    );

endmodule

// File: verif/fetchChecker.sv
`timescale 1ns/1ps

module fetchChecker (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                instrReadEnable,
    input  fetchPkg::BlockAddr  instrAddr,
    input  fetchPkg::PrivLevel  priv,
    input  logic                interruptPending,
    input  logic                outValid,
    input  fetchPkg::Addr       outPc,
    input  fetchPkg::FetchId    outFetchId,
    input  fetchPkg::FetchFault outFault,
    input  fetchPkg::InstrBlock outInstrs,
    input  fetchPkg::HalfOffs   outFirstValid,
    input  fetchPkg::HalfOffs   outLastValid,
    input  logic                outPredTaken,
    input  fetchPkg::Addr       outPredTarget,
    input  logic                expValid,
    input  fetchPkg::Addr       expPc,
    input  fetchPkg::FetchId    expId,
    input  logic [1:0]          expFault,
    input  fetchPkg::HalfOffs   expFirst,
    input  fetchPkg::HalfOffs   expLast,
    input  logic                expTaken,
    input  fetchPkg::Addr       expTarget,
    input  logic                testDone,
    input  logic                reportReq,
    output int                  pendingCount,
    output int                  errorCount
);
    import fetchPkg::*;

    typedef struct packed {
        Addr pc;
        FetchId id;
        logic [1:0] fault;
        HalfOffs first;
        HalfOffs last;
        logic taken;
        Addr target;
    } Expected;

    Expected expQ[$];
    int testPackets = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;

    initial begin
        pendingCount = 0;
        errorCount = 0;
    end

    // Halfword i of block b holds b*8+i
    function automatic InstrBlock blockInstrs(BlockAddr b);
        InstrBlock data;
        logic [30:0] word;
        for (int i = 0; i < 8; i++) begin
            word = {b, 3'b000} + 31'(i);
            data[i*16 +: 16] = word[15:0];
        end
        return data;
    endfunction

    function automatic void noteError();
        testErrors++;
        errorCount++;
    endfunction

    function automatic void checkField(string name, logic [127:0] expVal, logic [127:0] actVal);
        if (expVal !== actVal) begin
            $display("Fail %s expected %0h actual %0h", name, expVal, actVal);
            noteError();
        end
    endfunction

    // Sampled on the falling edge while the outputs are stable
    always @(negedge clk) begin : watch
        Expected e;
        InstrBlock expInstrs;
        if (expValid) begin
            expQ.push_back({expPc, expId, expFault, expFirst, expLast, expTaken, expTarget});
        end
        if (!rst && instrReadEnable) begin
            if (!en) begin
                $display("Read issued at block %h while en is low", instrAddr);
                noteError();
            end
            if (instrAddr[27:24] == mmioRegion) begin
                $display("Read issued at block %h in the mmio region", instrAddr);
                noteError();
            end
            if ((priv == privUser) && instrAddr[27]) begin
                $display("Read issued at block %h above the user range in user mode",
                    instrAddr);
                noteError();
            end
            if (interruptPending) begin
                $display("Read issued at block %h with an interrupt pending", instrAddr);
                noteError();
            end
        end
        if (!rst && outValid) begin
            testPackets++;
            if (expQ.size() == 0) begin
                $display("Unexpected packet at pc %h with fetch ID %h", outPc, outFetchId);
                noteError();
            end else begin
                e = expQ.pop_front();
                expInstrs = (e.fault != 2'd0) ? '0 : blockInstrs(e.pc[31:4]);
                checkField("outPc", 128'(e.pc), 128'(outPc));
                checkField("outFetchId", 128'(e.id), 128'(outFetchId));
                checkField("outFault", 128'(e.fault), 128'(outFault));
                checkField("outFirstValid", 128'(e.first), 128'(outFirstValid));
                checkField("outLastValid", 128'(e.last), 128'(outLastValid));
                checkField("outPredTaken", 128'(e.taken), 128'(outPredTaken));
                checkField("outPredTarget", 128'(e.target), 128'(outPredTarget));
                checkField("outInstrs", expInstrs, outInstrs);
            end
        end
        if (testDone) begin
            if (expQ.size() != 0) begin
                $display("%0d expected packets never arrived", expQ.size());
                noteError();
                expQ.delete();
            end
            testsRun++;
            if (testErrors != 0) begin
                testsFailed++;
            end
            $display("Test %0d: %0d packets, %0d errors", testsRun, testPackets, testErrors);
            testPackets = 0;
            testErrors = 0;
        end
        if (reportReq) begin
            $display("Summary: %0d tests, %0d failed, %0d errors",
                testsRun, testsFailed, errorCount);
        end
        pendingCount = expQ.size();
    end

endmodule

// File: verif/fetchTb.sv
`timescale 1ns/1ps

module fetchTb;
    import fetchPkg::*;

    localparam string casesPath = "verif/fetchCases.txt";

    logic clk;
    logic rst;
    logic en;
    logic redirectValid;
    Addr redirectPc;
    FetchId redirectFetchId;
    PrivLevel priv;
    logic interruptPending;
    logic updValid;
    Addr updPc;
    Addr updTarget;
    logic updTaken;
    logic updIsJump;
    HalfOffs updOffs;
    logic instrReadEnable;
    BlockAddr instrAddr;
    InstrBlock instrRaw;
    logic outValid;
    Addr outPc;
    FetchId outFetchId;
    FetchFault outFault;
    InstrBlock outInstrs;
    HalfOffs outFirstValid;
    HalfOffs outLastValid;
    logic outPredTaken;
    Addr outPredTarget;

    logic expValid;
    Addr expPc;
    FetchId expId;
    logic [1:0] expFault;
    HalfOffs expFirst;
    HalfOffs expLast;
    logic expTaken;
    Addr expTarget;
    logic testDone;
    logic reportReq;
    int pendingCount;
    int errorCount;

    integer seed = 32'h025204df;
    int cycles = 0;
    int cycleLimit = 1000000;

    fetchTop uut (.*);

    fetchChecker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic InstrBlock memBlock(BlockAddr b);
        InstrBlock data;
        logic [30:0] word;
        for (int i = 0; i < 8; i++) begin
            word = {b, 3'b000} + 31'(i);
            data[i*16 +: 16] = word[15:0];
        end
        return data;
    endfunction

    // Registered read that keeps the block on the bus only for the next cycle
    always @(posedge clk) begin
        if (instrReadEnable) begin
            instrRaw <= memBlock(instrAddr);
        end else begin
            instrRaw <= '0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d expected packets never arrived",
                cycles, pendingCount);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic randBit();
        integer r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic int countPackets();
        int fd;
        int n;
        int total;
        string line;
        string kw;
        total = 0;
        fd = $fopen(casesPath, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", kw);
                if (n == 1 && kw == "pkt") begin
                    total++;
                end
            end
            $fclose(fd);
        end
        return total;
    endfunction

    // Every command starts on a rising edge and drops last cycle's strobes
    task automatic nextCycle();
        @(posedge clk);
        redirectValid <= 1'b0;
        updValid <= 1'b0;
        expValid <= 1'b0;
        testDone <= 1'b0;
        reportReq <= 1'b0;
    endtask

    task automatic runUntilDrained(input bit randomEn, input int idle);
        bit drained;
        drained = 1'b0;
        nextCycle();
        while (!drained) begin
            @(posedge clk);
            if (pendingCount == 0) begin
                drained = 1'b1;
            end else begin
                en <= randomEn ? randBit() : 1'b1;
            end
        end
        repeat (idle) begin
            en <= randomEn ? randBit() : 1'b1;
            @(posedge clk);
        end
        // Stall so the running stream stops before the next test
        en <= 1'b0;
        repeat (2) @(posedge clk);
        nextCycle();
        testDone <= 1'b1;
    endtask

    task automatic runCases(input int fd);
        string line;
        string kw;
        string mode;
        logic [31:0] a, b, c, d, e, f, g;
        int n;
        int idle;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", kw);
            if (n == 1 && kw.getc(0) != "#" && kw != "test") begin
                if (kw == "run") begin
                    n = $sscanf(line, "%s %s %d", kw, mode, idle);
                    runUntilDrained(mode == "random", idle);
                end else begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h", kw, a, b, c, d, e, f, g);
                    nextCycle();
                    if (kw == "redirect") begin
                        redirectValid <= 1'b1;
                        redirectPc <= a;
                        redirectFetchId <= b[4:0];
                    end else if (kw == "update") begin
                        updValid <= 1'b1;
                        updPc <= a;
                        updTarget <= b;
                        updTaken <= c[0];
                        updIsJump <= d[0];
                        updOffs <= e[2:0];
                    end else if (kw == "priv") begin
                        priv <= a[0] ? privSupervisor : privUser;
                    end else if (kw == "irq") begin
                        interruptPending <= a[0];
                    end else if (kw == "pkt") begin
                        expValid <= 1'b1;
                        expPc <= a;
                        expId <= b[4:0];
                        expFault <= c[1:0];
                        expFirst <= d[2:0];
                        expLast <= e[2:0];
                        expTaken <= f[0];
                        expTarget <= g;
                    end else begin
                        $display("Unknown command %s in the cases file", kw);
                        cycleLimit = 0;
                    end
                end
            end
        end
    endtask

    initial begin : stimulus
        int fd;
        rst <= 1'b1;
        en <= 1'b0;
        redirectValid <= 1'b0;
        redirectPc <= '0;
        redirectFetchId <= '0;
        priv <= privSupervisor;
        interruptPending <= 1'b0;
        updValid <= 1'b0;
        updPc <= '0;
        updTarget <= '0;
        updTaken <= 1'b0;
        updIsJump <= 1'b0;
        updOffs <= '0;
        instrRaw <= '0;
        expValid <= 1'b0;
        expPc <= '0;
        expId <= '0;
        expFault <= '0;
        expFirst <= '0;
        expLast <= '0;
        expTaken <= 1'b0;
        expTarget <= '0;
        testDone <= 1'b0;
        reportReq <= 1'b0;
        cycleLimit = countPackets() * 8 + 50;
        fd = $fopen(casesPath, "r");
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        if (fd == 0) begin
            $display("Cannot open the cases file %s", casesPath);
            $display("Simulation failed");
        end else begin
            runCases(fd);
            $fclose(fd);
            nextCycle();
            reportReq <= 1'b1;
            nextCycle();
            if (errorCount == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

// File: verif/fetchCases.txt
# Numbers in hex. Commands: test name | priv level | irq level | redirect pc fetchId
# update pc target taken isJump offs | pkt pc id fault first last taken target | run en idle
test seqReset
pkt 00001000 00 0 0 7 0 00000000
pkt 00001010 01 0 0 7 0 00000000
pkt 00001020 02 0 0 7 0 00000000
pkt 00001030 03 0 0 7 0 00000000
run steady 0
test redirectMid
redirect 00001236 04
pkt 00001236 05 0 3 7 0 00000000
pkt 00001240 06 0 0 7 0 00000000
pkt 00001250 07 0 0 7 0 00000000
run steady 0
test btbTaken
update 0000200a 00003004 1 0 5
redirect 00002000 07
pkt 00002000 08 0 0 5 1 00003004
pkt 00003004 09 0 2 7 0 00000000
pkt 00003010 0a 0 0 7 0 00000000
run steady 0
test btbNotTaken
update 0000200a 00003004 0 0 5
update 0000200a 00003004 0 0 5
redirect 00002000 10
pkt 00002000 11 0 0 7 0 00000000
pkt 0000200c 12 0 6 7 0 00000000
pkt 00002010 13 0 0 7 0 00000000
run steady 0
test mmioFault
redirect f0000000 0a
pkt f0000000 0b 1 0 7 0 00000000
run steady 8
test privFault
priv 0
redirect 80000000 0c
pkt 80000000 0d 2 0 7 0 00000000
run steady 8
test irqFault
priv 1
irq 1
redirect 00001000 14
pkt 00001000 15 3 0 7 0 00000000
run steady 8
test randSeq
irq 0
redirect 00001000 1f
pkt 00001000 00 0 0 7 0 00000000
pkt 00001010 01 0 0 7 0 00000000
pkt 00001020 02 0 0 7 0 00000000
pkt 00001030 03 0 0 7 0 00000000
run random 0
test randBtb
update 0000200a 00003004 1 0 5
update 0000200a 00003004 1 0 5
redirect 00002000 07
pkt 00002000 08 0 0 5 1 00003004
pkt 00003004 09 0 2 7 0 00000000
pkt 00003010 0a 0 0 7 0 00000000
run random 0

// File: project.f
hw/fetchPkg.sv
hw/predPkg.sv
hw/predIf.sv
hw/branchPredictor.sv
hw/fetchGuard.sv
hw/fetchSequencer.sv
hw/fetchTop.sv
verif/fetchChecker.sv
verif/fetchTb.sv

// File: run.sh
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module fetchTb \
    -Mdir obj_dir -o fetchSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/fetchSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator returned status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
